//--- if_stage.f
logic/if_cfg_pkg.sv
logic/if_types_pkg.sv
logic/fetch_if.sv
logic/pc_select.sv
logic/prefetch_buffer.sv
logic/if_id_regs.sv
logic/pc_incr_check.sv
logic/if_stage.sv
tb/tb_clock_gen.sv
tb/if_stage_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= if_stage_tb
FILELIST  ?= if_stage.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= TEST PASSED

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output
run: compile
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

//--- tb/if_stage_tb.sv
/*
  testbench for the instruction fetch stage
  bus responder, ID side stimulus, scoreboard assertions and watchdog
*/

module if_stage_tb;

  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;

  // memory returns the address xor this pattern
  localparam logic [31:0] MEM_PATTERN  = 32'hA5A5_0000;
  // low bits of the boot address are ignored, target is base plus 0x80
  localparam logic [31:0] BOOT_ADDR    = 32'h2000_0044;
  localparam logic [31:0] BOOT_TARGET  = 32'h2000_0080;
  localparam logic [31:0] MTVEC        = 32'h0000_4123;
  localparam logic [31:0] MTVEC_BASE   = 32'h0000_4100;
  localparam logic [31:0] MEPC         = 32'h0000_9010;
  localparam logic [31:0] DEPC         = 32'h0000_A020;
  // debug module halt and exception entries
  localparam logic [31:0] HALT_ADDR    = 32'h1A11_0800;
  localparam logic [31:0] DBG_EXC_ADDR = 32'h1A11_0808;
  // seventh word of the boot stream comes back with a bus error
  localparam logic [31:0] ERR_ADDR     = 32'h2000_0098;

  ////////////////////////////////////////////////////
  // watchdog budget from the test lengths
  ////////////////////////////////////////////////////

  localparam int BOOT_WORDS      = 12;
  localparam int REDIRECT_WORDS  = 6;
  localparam int N_REDIRECTS     = 10;
  // idle, hold test and words between paired redirects
  localparam int SPARE_WORDS     = 8;
  localparam int CYCLES_PER_WORD = 50;
  localparam int WATCHDOG_CYCLES =
    (BOOT_WORDS + N_REDIRECTS * REDIRECT_WORDS + SPARE_WORDS) * CYCLES_PER_WORD;

  logic clk_i;
  logic rst_ni;
  logic req_i;
  logic instr_req_o;
  logic [31:0] instr_addr_o;
  logic instr_gnt_i;
  logic instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic instr_bus_err_i;
  logic instr_valid_id_o;
  logic instr_new_id_o;
  logic [31:0] instr_rdata_id_o;
  logic instr_fetch_err_o;
  logic [31:0] pc_if_o;
  logic [31:0] pc_id_o;
  logic instr_valid_clear_i;
  logic pc_set_i;
  if_types_pkg::pc_sel_e pc_mux_i;
  if_types_pkg::exc_pc_sel_e exc_pc_mux_i;
  logic irq_int_i;
  logic [4:0] irq_code_i;
  logic [31:0] branch_target_ex_i;
  logic [31:0] csr_mtvec_i;
  logic csr_mtvec_init_o;
  logic id_in_ready_i;
  logic pc_mismatch_alert_o;
  logic if_busy_o;

  integer seed = 32'h7912_87e1;
  int error_count = 0;
  // ID side randomized unless a test holds it
  logic id_random;
  logic [31:0] exp_target;

  // scoreboard state, sampled at the rising edge
  logic booted;
  logic id_loaded;
  logic valid_prev;
  logic clear_prev;
  logic ready_prev;
  logic [31:0] exp_pc;
  logic [31:0] exp_req_addr;
  logic [31:0] pc_id_prev;
  logic [31:0] rdata_prev;
  // fetch address offered to ID at the last edge
  logic [31:0] pc_if_prev;

  // bus responder, granted words not yet returned
  logic [31:0] pend_q[$];
  logic [31:0] rsp_addr;
  int in_flight = 0;

  tb_clock_gen #(.PERIOD(CLK_PERIOD), .RESET_CYCLES(3)) clock_gen_inst (
    .clk_o  (clk_i),
    .rst_no (rst_ni)
  );

  if_stage if_stage_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .req_i               (req_i),
    .boot_addr_i         (BOOT_ADDR),
    .instr_req_o         (instr_req_o),
    .instr_addr_o        (instr_addr_o),
    .instr_gnt_i         (instr_gnt_i),
    .instr_rvalid_i      (instr_rvalid_i),
    .instr_rdata_i       (instr_rdata_i),
    .instr_bus_err_i     (instr_bus_err_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .pc_if_o             (pc_if_o),
    .pc_id_o             (pc_id_o),
    .instr_valid_clear_i (instr_valid_clear_i),
    .pc_set_i            (pc_set_i),
    .pc_mux_i            (pc_mux_i),
    .exc_pc_mux_i        (exc_pc_mux_i),
    .irq_int_i           (irq_int_i),
    .irq_code_i          (irq_code_i),
    .branch_target_ex_i  (branch_target_ex_i),
    .csr_mepc_i          (MEPC),
    .csr_depc_i          (DEPC),
    .csr_mtvec_i         (csr_mtvec_i),
    .csr_mtvec_init_o    (csr_mtvec_init_o),
    .id_in_ready_i       (id_in_ready_i),
    .pc_mismatch_alert_o (pc_mismatch_alert_o),
    .if_busy_o           (if_busy_o)
  );

  ////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////

  function automatic logic chance(input int pct);
    chance = (($random(seed) & 32'h7FFF_FFFF) % 100) < pct;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    error_count++;
    $display("MISMATCH %s expected %08h actual %08h", name, expected, actual);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_error(input string what);
    error_count++;
    $display("ERROR %s", what);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic step();
    @(posedge clk_i);
    #DRIVE_DLY;
  endtask

  // count new instructions in ID, sampled mid cycle
  task automatic wait_words(input int n);
    int seen;
    seen = 0;
    while (seen < n) begin
      @(negedge clk_i);
      if (instr_new_id_o) seen++;
    end
    step();
  endtask

  // one cycle pc set, target worked out by the caller
  task automatic redirect(input if_types_pkg::pc_sel_e sel,
                          input if_types_pkg::exc_pc_sel_e exc_sel,
                          input logic irq_int, input logic [4:0] code,
                          input logic [31:0] target);
    pc_set_i     = 1'b1;
    pc_mux_i     = sel;
    exc_pc_mux_i = exc_sel;
    irq_int_i    = irq_int;
    irq_code_i   = code;
    exp_target   = target;
    step();
    pc_set_i = 1'b0;
  endtask

  ////////////////////////////////////////////////////
  // bus responder and random ID side
  ////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (instr_req_o && instr_gnt_i) begin
      pend_q.push_back(instr_addr_o);
    end
    #DRIVE_DLY;
    instr_gnt_i = chance(60);
    // in order return, at least one cycle after the grant
    if (pend_q.size() > 0 && chance(70)) begin
      rsp_addr        = pend_q.pop_front();
      instr_rvalid_i  = 1'b1;
      instr_rdata_i   = rsp_addr ^ MEM_PATTERN;
      instr_bus_err_i = (rsp_addr == ERR_ADDR);
    end else begin
      instr_rvalid_i  = 1'b0;
      instr_rdata_i   = 32'h0;
      instr_bus_err_i = 1'b0;
    end
    in_flight = pend_q.size() + (instr_rvalid_i ? 1 : 0);
    if (id_random) begin
      id_in_ready_i       = chance(60);
      instr_valid_clear_i = chance(30);
    end
  end

  ////////////////////////////////////////////////////
  // scoreboard model
  ////////////////////////////////////////////////////

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      booted       <= 1'b0;
      id_loaded    <= 1'b0;
      valid_prev   <= 1'b0;
      clear_prev   <= 1'b0;
      ready_prev   <= 1'b0;
      exp_pc       <= 32'h0;
      exp_req_addr <= 32'h0;
      pc_id_prev   <= 32'h0;
      rdata_prev   <= 32'h0;
      pc_if_prev   <= 32'h0;
    end else begin
      // a pc set restarts both the bus and the ID stream
      if (pc_set_i) begin
        booted       <= 1'b1;
        exp_pc       <= exp_target;
        exp_req_addr <= exp_target;
      end else begin
        if (instr_new_id_o) exp_pc <= exp_pc + 32'd4;
        if (instr_req_o && instr_gnt_i) exp_req_addr <= exp_req_addr + 32'd4;
      end
      if (instr_new_id_o) id_loaded <= 1'b1;
      valid_prev <= instr_valid_id_o;
      clear_prev <= instr_valid_clear_i;
      ready_prev <= id_in_ready_i;
      pc_id_prev <= pc_id_o;
      rdata_prev <= instr_rdata_id_o;
      pc_if_prev <= pc_if_o;
    end
  end

  ////////////////////////////////////////////////////
  // checks, sampled at the falling edge
  ////////////////////////////////////////////////////

  mtvec_init_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o == (pc_set_i && pc_mux_i == if_types_pkg::PC_BOOT))
    else report_mismatch("mtvec_init",
                         32'(pc_set_i && pc_mux_i == if_types_pkg::PC_BOOT),
                         32'(csr_mtvec_init_o));

  idle_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    !booted |-> !(instr_req_o || instr_valid_id_o || instr_new_id_o ||
                  pc_mismatch_alert_o || if_busy_o))
    else report_error("fetch activity before the first pc set");

  req_addr_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> instr_addr_o == exp_req_addr)
    else report_mismatch("req_addr", exp_req_addr, instr_addr_o);

  seq_pc_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> pc_id_o == exp_pc)
    else report_mismatch("pc_id", exp_pc, pc_id_o);

  // the word taken into ID was the one offered at the edge before
  pc_if_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> pc_if_prev == exp_pc)
    else report_mismatch("pc_if", exp_pc, pc_if_prev);

  // stale data would not match the pattern of the expected pc
  rdata_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_rdata_id_o == (exp_pc ^ MEM_PATTERN))
    else report_mismatch("rdata_id", exp_pc ^ MEM_PATTERN, instr_rdata_id_o);

  fetch_err_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_fetch_err_o == (exp_pc == ERR_ADDR))
    else report_mismatch("fetch_err", 32'(exp_pc == ERR_ADDR), 32'(instr_fetch_err_o));

  alert_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    !pc_mismatch_alert_o)
    else report_error("pc mismatch alert raised on a sequential stream");

  // valid is set by a transfer and held until the cycle after a clear
  valid_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    instr_valid_id_o == (instr_new_id_o || (valid_prev && !clear_prev)))
    else report_mismatch("valid_id", 32'(instr_new_id_o || (valid_prev && !clear_prev)),
                         32'(instr_valid_id_o));

  new_ready_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> ready_prev)
    else report_error("new instruction in ID without ready in the cycle before");

  pc_frozen_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    (id_loaded && !instr_new_id_o) |-> pc_id_o == pc_id_prev)
    else report_mismatch("pc_id_frozen", pc_id_prev, pc_id_o);

  rdata_frozen_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    (id_loaded && !instr_new_id_o) |-> instr_rdata_id_o == rdata_prev)
    else report_mismatch("rdata_id_frozen", rdata_prev, instr_rdata_id_o);

  in_flight_check: assert property (@(negedge clk_i) disable iff (!rst_ni)
    in_flight <= if_cfg_pkg::FIFO_DEPTH)
    else report_mismatch("in_flight", 32'(if_cfg_pkg::FIFO_DEPTH), 32'(in_flight));

  ////////////////////////////////////////////////////
  // test sequence
  ////////////////////////////////////////////////////

  initial begin
    req_i               = 1'b0;
    instr_gnt_i         = 1'b0;
    instr_rvalid_i      = 1'b0;
    instr_rdata_i       = 32'h0;
    instr_bus_err_i     = 1'b0;
    instr_valid_clear_i = 1'b0;
    pc_set_i            = 1'b0;
    pc_mux_i            = if_types_pkg::PC_BOOT;
    exc_pc_mux_i        = if_types_pkg::EXC_PC_EXC;
    irq_int_i           = 1'b0;
    irq_code_i          = 5'd0;
    branch_target_ex_i  = 32'h0;
    csr_mtvec_i         = MTVEC;
    id_in_ready_i       = 1'b0;
    id_random           = 1'b1;
    exp_target          = 32'h0;

    wait (rst_ni === 1'b1);
    // fetch stays idle until the boot pc set
    repeat (4) step();
    req_i = 1'b1;
    redirect(if_types_pkg::PC_BOOT, if_types_pkg::EXC_PC_EXC, 1'b0, 5'd0, BOOT_TARGET);
    wait_words(BOOT_WORDS);

    branch_target_ex_i = 32'h0000_8000;
    redirect(if_types_pkg::PC_JUMP, if_types_pkg::EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_8000);
    wait_words(REDIRECT_WORDS);
    redirect(if_types_pkg::PC_ERET, if_types_pkg::EXC_PC_EXC, 1'b0, 5'd0, MEPC);
    wait_words(REDIRECT_WORDS);
    redirect(if_types_pkg::PC_DRET, if_types_pkg::EXC_PC_EXC, 1'b0, 5'd0, DEPC);
    wait_words(REDIRECT_WORDS);

    // trap entries, vectored interrupts step by one word per cause
    redirect(if_types_pkg::PC_EXC, if_types_pkg::EXC_PC_EXC, 1'b0, 5'd0, MTVEC_BASE);
    wait_words(REDIRECT_WORDS);
    redirect(if_types_pkg::PC_EXC, if_types_pkg::EXC_PC_IRQ, 1'b0, 5'd5,
             MTVEC_BASE + 32'd4 * 32'd5);
    wait_words(REDIRECT_WORDS);
    redirect(if_types_pkg::PC_EXC, if_types_pkg::EXC_PC_IRQ, 1'b1, 5'd3,
             MTVEC_BASE + 32'd4 * 32'd31);
    wait_words(REDIRECT_WORDS);
    redirect(if_types_pkg::PC_EXC, if_types_pkg::EXC_PC_DBD, 1'b0, 5'd0, HALT_ADDR);
    wait_words(REDIRECT_WORDS);
    redirect(if_types_pkg::PC_EXC, if_types_pkg::EXC_PC_DBG_EXC, 1'b0, 5'd0, DBG_EXC_ADDR);
    wait_words(REDIRECT_WORDS);

    // back to back pc sets leave stale responses on the bus
    branch_target_ex_i = 32'h0000_C000;
    redirect(if_types_pkg::PC_JUMP, if_types_pkg::EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_C000);
    branch_target_ex_i = 32'h0000_C100;
    redirect(if_types_pkg::PC_JUMP, if_types_pkg::EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_C100);
    wait_words(REDIRECT_WORDS);
    branch_target_ex_i = 32'h0000_D000;
    redirect(if_types_pkg::PC_JUMP, if_types_pkg::EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_D000);
    wait_words(1);
    branch_target_ex_i = 32'h0000_E000;
    redirect(if_types_pkg::PC_JUMP, if_types_pkg::EXC_PC_EXC, 1'b0, 5'd0, 32'h0000_E000);
    wait_words(REDIRECT_WORDS);

    // ID stalled, the word in ID must hold until cleared
    @(posedge clk_i);
    id_random = 1'b0;
    #DRIVE_DLY;
    instr_valid_clear_i = 1'b0;
    id_in_ready_i       = 1'b1;
    wait_words(1);
    id_in_ready_i = 1'b0;
    repeat (6) step();
    instr_valid_clear_i = 1'b1;
    step();
    instr_valid_clear_i = 1'b0;
    repeat (3) step();

    req_i = 1'b0;
    id_random = 1'b1;
    repeat (4) step();

    if (error_count == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      $display("TEST FAILED");
      $fatal(1, "%0d checks failed", error_count);
    end
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, fetch stream stalled", WATCHDOG_CYCLES);
    $display("TEST FAILED");
    $fatal(1, "timeout");
  end

endmodule

//--- tb/tb_clock_gen.sv
/*
  testbench clock and reset generator
*/

module tb_clock_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 3
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD / 2) clk_o = ~clk_o;
  end

  // release just after an edge, like every other input
  initial begin
    rst_no = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    #10;
    rst_no = 1'b1;
  end

endmodule

//--- logic/if_stage.sv
/*
  instruction fetch stage top level
  pc mux, prefetch buffer, IF-ID register and pc check
*/

module if_stage (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      req_i,
  input  if_types_pkg::addr_t       boot_addr_i,

  // instruction bus
  output logic                      instr_req_o,
  output if_types_pkg::addr_t       instr_addr_o,
  input  logic                      instr_gnt_i,
  input  logic                      instr_rvalid_i,
  input  if_types_pkg::instr_t      instr_rdata_i,
  input  logic                      instr_bus_err_i,

  // toward ID
  output logic                      instr_valid_id_o,
  output logic                      instr_new_id_o,
  output if_types_pkg::instr_t      instr_rdata_id_o,
  output logic                      instr_fetch_err_o,
  output if_types_pkg::addr_t       pc_if_o,
  output if_types_pkg::addr_t       pc_id_o,

  // control from ID and the controller
  input  logic                      instr_valid_clear_i,
  input  logic                      pc_set_i,
  input  if_types_pkg::pc_sel_e     pc_mux_i,
  input  if_types_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic                      irq_int_i,
  input  if_types_pkg::irq_code_t   irq_code_i,
  input  if_types_pkg::addr_t       branch_target_ex_i,

  // CSR file
  input  if_types_pkg::addr_t       csr_mepc_i,
  input  if_types_pkg::addr_t       csr_depc_i,
  input  if_types_pkg::addr_t       csr_mtvec_i,
  output logic                      csr_mtvec_init_o,

  input  logic                      id_in_ready_i,
  output logic                      pc_mismatch_alert_o,
  output logic                      if_busy_o
);

  if_types_pkg::addr_t fetch_addr_n;

  fetch_if fetch_bus ();

  pc_select pc_select_inst (
    .pc_set_i           (pc_set_i),
    .pc_mux_i           (pc_mux_i),
    .exc_pc_mux_i       (exc_pc_mux_i),
    .irq_int_i          (irq_int_i),
    .irq_code_i         (irq_code_i),
    .boot_addr_i        (boot_addr_i),
    .branch_target_ex_i (branch_target_ex_i),
    .csr_mepc_i         (csr_mepc_i),
    .csr_depc_i         (csr_depc_i),
    .csr_mtvec_i        (csr_mtvec_i),
    .fetch_addr_n_o     (fetch_addr_n),
    .csr_mtvec_init_o   (csr_mtvec_init_o)
  );

  // every pc set redirects the prefetcher
  prefetch_buffer prefetch_buffer_inst (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (fetch_addr_n),
    .fetch           (fetch_bus.producer),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_rdata_i   (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i),
    .busy_o          (if_busy_o)
  );

  if_id_regs if_id_regs_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch               (fetch_bus.consumer),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o)
  );

  pc_incr_check pc_incr_check_inst (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch               (fetch_bus.consumer),
    .pc_set_i            (pc_set_i),
    .pc_id_i             (pc_id_o),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // address of the word offered to ID
  assign pc_if_o = fetch_bus.addr;

endmodule

//--- logic/pc_incr_check.sv
/*
  sequential pc consistency tracker and mismatch alert
*/

module pc_incr_check (
  input  logic                clk_i,
  input  logic                rst_ni,
  fetch_if.consumer           fetch,
  input  logic                pc_set_i,
  input  if_types_pkg::addr_t pc_id_i,
  output logic                pc_mismatch_alert_o
);

  logic                transfer;
  logic                seq_armed_d, seq_armed_q;
  if_types_pkg::addr_t pc_expected;

  // observe only, ready is driven by the IF-ID register
  assign transfer = fetch.valid & fetch.ready & ~pc_set_i;

  // armed after a word reaches ID, dropped on redirect or faulting fetch
  assign seq_armed_d = (seq_armed_q | transfer) & ~pc_set_i & ~(transfer & fetch.err);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_armed_q <= 1'b0;
    end else begin
      seq_armed_q <= seq_armed_d;
    end
  end

  // next word must follow the one in ID
  assign pc_expected = pc_id_i + if_types_pkg::addr_t'(if_cfg_pkg::INSTR_BYTES);

  assign pc_mismatch_alert_o = seq_armed_q & fetch.valid & (fetch.addr != pc_expected);

endmodule

//--- logic/if_id_regs.sv
/*
  IF-ID valid and new flags, pipeline registers
  frozen while ID stalls
*/

module if_id_regs (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  fetch_if.consumer              fetch,
  input  logic                   id_in_ready_i,
  input  logic                   pc_set_i,
  input  logic                   instr_valid_clear_i,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output logic                   instr_fetch_err_o,
  output if_types_pkg::instr_t   instr_rdata_id_o,
  output if_types_pkg::addr_t    pc_id_o
);

  logic transfer;
  logic instr_valid_id_d, instr_valid_id_q;
  logic instr_new_id_q;

  // ID stall goes straight back to the prefetch queue
  assign fetch.ready = id_in_ready_i;

  // a pc set squashes the word on offer
  assign transfer = fetch.valid & fetch.ready & ~pc_set_i;

  //////////////////////////////////////////////////
  // valid and new flags
  //////////////////////////////////////////////////

  // valid holds until cleared by ID
  assign instr_valid_id_d = transfer | (instr_valid_id_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_q <= 1'b0;
      instr_new_id_q   <= 1'b0;
    end else begin
      instr_valid_id_q <= instr_valid_id_d;
      // one cycle pulse per accepted word
      instr_new_id_q   <= transfer;
    end
  end

  assign instr_valid_id_o = instr_valid_id_q;
  assign instr_new_id_o   = instr_new_id_q;

  //////////////////////////////////////////////////
  // pipeline registers
  //////////////////////////////////////////////////

  // loaded only on transfer so ID sees a stable word
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o  <= '0;
      pc_id_o           <= '0;
      instr_fetch_err_o <= 1'b0;
    end else if (transfer) begin
      instr_rdata_id_o  <= fetch.rdata;
      pc_id_o           <= fetch.addr;
      instr_fetch_err_o <= fetch.err;
    end
  end

endmodule

//--- logic/prefetch_buffer.sv
/*
  instruction bus requester with outstanding tracking,
  response queue of FIFO_DEPTH words and flush on branch
*/

module prefetch_buffer (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   req_i,
  input  logic                   branch_i,
  input  if_types_pkg::addr_t    branch_addr_i,
  fetch_if.producer              fetch,
  output logic                   instr_req_o,
  output if_types_pkg::addr_t    instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  if_types_pkg::instr_t   instr_rdata_i,
  input  logic                   instr_bus_err_i,
  output logic                   busy_o
);

  logic                   fetch_en_q;
  logic                   req_hold_q;
  logic                   can_req;
  logic                   gnt_acc;
  logic                   rvalid_keep;
  logic                   rvalid_drop;
  logic                   push;
  logic                   pop;
  if_types_pkg::addr_t    branch_addr;
  if_types_pkg::addr_t    addr_q;
  if_types_pkg::addr_t    rsp_addr_q;
  if_types_pkg::fifo_ptr_t out_cnt_q, out_cnt_d;
  if_types_pkg::fifo_ptr_t discard_cnt_q, discard_cnt_d;
  if_types_pkg::fifo_ptr_t fifo_cnt_q, fifo_cnt_d;
  logic [$clog2(if_cfg_pkg::FIFO_DEPTH)-1:0] rd_ptr_q, wr_ptr_q;

  // queue storage
  if_types_pkg::instr_t   fifo_rdata_q [if_cfg_pkg::FIFO_DEPTH];
  if_types_pkg::addr_t    fifo_addr_q  [if_cfg_pkg::FIFO_DEPTH];
  logic                   fifo_err_q   [if_cfg_pkg::FIFO_DEPTH];

  // word aligned target
  assign branch_addr = {branch_addr_i[31:2], 2'b00};

  //////////////////////////////////////////////////
  // bus request side
  //////////////////////////////////////////////////

  // room on the bus and in the queue for one more word
  assign can_req = ((out_cnt_q + discard_cnt_q) < if_cfg_pkg::FIFO_DEPTH) &&
                   ((out_cnt_q + fifo_cnt_q) < if_cfg_pkg::FIFO_DEPTH);

  // a raised request holds until granted, no new request in the branch cycle
  assign instr_req_o  = req_hold_q | (fetch_en_q & req_i & can_req & ~branch_i);
  assign instr_addr_o = addr_q;
  assign gnt_acc      = instr_req_o & instr_gnt_i;

  // responses return in order, stale ones come first
  assign rvalid_drop = instr_rvalid_i & (discard_cnt_q != '0);
  assign rvalid_keep = instr_rvalid_i & (discard_cnt_q == '0);

  always_comb begin
    if (branch_i) begin
      // everything in flight becomes stale, this cycle's response too
      discard_cnt_d = discard_cnt_q + out_cnt_q + if_types_pkg::fifo_ptr_t'(gnt_acc)
                      - if_types_pkg::fifo_ptr_t'(instr_rvalid_i);
      out_cnt_d     = '0;
    end else begin
      discard_cnt_d = discard_cnt_q - if_types_pkg::fifo_ptr_t'(rvalid_drop);
      out_cnt_d     = out_cnt_q + if_types_pkg::fifo_ptr_t'(gnt_acc)
                      - if_types_pkg::fifo_ptr_t'(rvalid_keep);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fetch_en_q    <= 1'b0;
      req_hold_q    <= 1'b0;
      out_cnt_q     <= '0;
      discard_cnt_q <= '0;
      addr_q        <= '0;
      rsp_addr_q    <= '0;
    end else begin
      // idle until the first pc set
      if (branch_i) begin
        fetch_en_q <= 1'b1;
      end
      req_hold_q    <= instr_req_o & ~instr_gnt_i;
      out_cnt_q     <= out_cnt_d;
      discard_cnt_q <= discard_cnt_d;
      // request address steps per grant
      if (branch_i) begin
        addr_q <= branch_addr;
      end else if (gnt_acc) begin
        addr_q <= addr_q + if_types_pkg::addr_t'(if_cfg_pkg::INSTR_BYTES);
      end
      // address of the next kept response
      if (branch_i) begin
        rsp_addr_q <= branch_addr;
      end else if (push) begin
        rsp_addr_q <= rsp_addr_q + if_types_pkg::addr_t'(if_cfg_pkg::INSTR_BYTES);
      end
    end
  end

  //////////////////////////////////////////////////
  // response queue
  //////////////////////////////////////////////////

  assign push = rvalid_keep & ~branch_i;
  assign pop  = fetch.valid & fetch.ready;

  always_comb begin
    if (branch_i) begin
      fifo_cnt_d = '0;
    end else begin
      fifo_cnt_d = fifo_cnt_q + if_types_pkg::fifo_ptr_t'(push)
                   - if_types_pkg::fifo_ptr_t'(pop);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      fifo_cnt_q <= '0;
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
    end else begin
      fifo_cnt_q <= fifo_cnt_d;
      if (branch_i) begin
        rd_ptr_q <= '0;
        wr_ptr_q <= '0;
      end else begin
        if (pop) begin
          rd_ptr_q <= (rd_ptr_q == if_cfg_pkg::FIFO_DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
        end
        if (push) begin
          wr_ptr_q <= (wr_ptr_q == if_cfg_pkg::FIFO_DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < if_cfg_pkg::FIFO_DEPTH; i++) begin
        fifo_rdata_q[i] <= '0;
        fifo_addr_q[i]  <= '0;
        fifo_err_q[i]   <= 1'b0;
      end
    end else if (push) begin
      fifo_rdata_q[wr_ptr_q] <= instr_rdata_i;
      fifo_addr_q[wr_ptr_q]  <= rsp_addr_q;
      fifo_err_q[wr_ptr_q]   <= instr_bus_err_i;
    end
  end

  // head of queue, squashed in the flush cycle
  assign fetch.valid = (fifo_cnt_q != '0) & ~branch_i;
  assign fetch.rdata = fifo_rdata_q[rd_ptr_q];
  assign fetch.addr  = fifo_addr_q[rd_ptr_q];
  assign fetch.err   = fifo_err_q[rd_ptr_q];

  assign busy_o = instr_req_o | (out_cnt_q != '0) | (discard_cnt_q != '0);

endmodule

//--- logic/pc_select.sv
/*
  exception pc mux, next fetch address mux
  and the mtvec init pulse to the CSR file
*/

module pc_select (
  input  logic                      pc_set_i,
  input  if_types_pkg::pc_sel_e     pc_mux_i,
  input  if_types_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  logic                      irq_int_i,
  input  if_types_pkg::irq_code_t   irq_code_i,
  input  if_types_pkg::addr_t       boot_addr_i,
  input  if_types_pkg::addr_t       branch_target_ex_i,
  input  if_types_pkg::addr_t       csr_mepc_i,
  input  if_types_pkg::addr_t       csr_depc_i,
  input  if_types_pkg::addr_t       csr_mtvec_i,
  output if_types_pkg::addr_t       fetch_addr_n_o,
  output logic                      csr_mtvec_init_o
);

  if_types_pkg::irq_code_t irq_vec;
  if_types_pkg::addr_t     mtvec_base;
  if_types_pkg::addr_t     boot_base;
  if_types_pkg::addr_t     exc_pc;

  // internal interrupts all take the nmi slot
  assign irq_vec = irq_int_i ? if_cfg_pkg::IRQ_NMI_CODE : irq_code_i;

  // vector bases, bits below VEC_BASE_LSB forced to zero
  assign mtvec_base = {csr_mtvec_i[31:if_cfg_pkg::VEC_BASE_LSB],
                       {if_cfg_pkg::VEC_BASE_LSB{1'b0}}};
  assign boot_base  = {boot_addr_i[31:if_cfg_pkg::VEC_BASE_LSB],
                       {if_cfg_pkg::VEC_BASE_LSB{1'b0}}};

  //////////////////////////////////////////////////
  // exception pc
  //////////////////////////////////////////////////

  always_comb begin
    unique case (exc_pc_mux_i)
      if_types_pkg::EXC_PC_EXC:     exc_pc = mtvec_base;
      // vectored mode, one word per cause
      if_types_pkg::EXC_PC_IRQ:     exc_pc = mtvec_base | if_types_pkg::addr_t'({irq_vec, 2'b00});
      if_types_pkg::EXC_PC_DBD:     exc_pc = if_cfg_pkg::DM_HALT_ADDR;
      if_types_pkg::EXC_PC_DBG_EXC: exc_pc = if_cfg_pkg::DM_EXC_ADDR;
      default:                      exc_pc = mtvec_base;
    endcase
  end

  //////////////////////////////////////////////////
  // next fetch address
  //////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      if_types_pkg::PC_BOOT: begin
        fetch_addr_n_o = boot_base | if_types_pkg::addr_t'(if_cfg_pkg::BOOT_OFFSET);
      end
      if_types_pkg::PC_JUMP: fetch_addr_n_o = branch_target_ex_i;
      // trap handler entry
      if_types_pkg::PC_EXC:  fetch_addr_n_o = exc_pc;
      // return from trap / debug
      if_types_pkg::PC_ERET: fetch_addr_n_o = csr_mepc_i;
      if_types_pkg::PC_DRET: fetch_addr_n_o = csr_depc_i;
      default: begin
        fetch_addr_n_o = boot_base | if_types_pkg::addr_t'(if_cfg_pkg::BOOT_OFFSET);
      end
    endcase
  end

  // CSR file loads mtvec from the boot address on this pulse
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == if_types_pkg::PC_BOOT);

endmodule

//--- logic/fetch_if.sv
/*
  fetched instruction channel from the prefetch buffer toward ID
*/

interface fetch_if;

  // word at the head of the prefetch queue
  logic                   valid;
  if_types_pkg::instr_t   rdata;
  if_types_pkg::addr_t    addr;
  // bus error returned with this word
  logic                   err;

  // ID can take the word this cycle
  logic                   ready;

  // prefetch buffer side
  modport producer (output valid, rdata, addr, err, input ready);

  // IF-ID register and pc check side
  modport consumer (input valid, rdata, addr, err, output ready);

endinterface

//--- logic/if_types_pkg.sv
/*
  types shared by the fetch stage modules
  address and instruction words, irq cause code, pc mux selectors
*/

package if_types_pkg;

  // byte address
  typedef logic [31:0] addr_t;

  // one 32-bit instruction word
  typedef logic [31:0] instr_t;

  // interrupt cause, lower bits of mcause
  typedef logic [4:0] irq_code_t;

  // count of queued or outstanding words
  typedef logic [1:0] fifo_ptr_t;

  //////////////////////////////////////////////////
  // pc mux selectors
  //////////////////////////////////////////////////

  // source of the next fetch address on a pc set
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // which trap handler the exception pc points to
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

endpackage

//--- logic/if_cfg_pkg.sv
/*
  fetch stage configuration constants
  debug module addresses, boot offset, vector base and buffer sizing
*/

package if_cfg_pkg;

  //////////////////////////////////////////////////
  // debug module entry points
  //////////////////////////////////////////////////

  // debug halt request lands here
  localparam logic [31:0] DM_HALT_ADDR = 32'h1A11_0800;
  // exception taken while in debug mode
  localparam logic [31:0] DM_EXC_ADDR  = 32'h1A11_0808;

  //////////////////////////////////////////////////
  // boot and trap vectors
  //////////////////////////////////////////////////

  // low byte of the boot address
  localparam logic [7:0] BOOT_OFFSET  = 8'h80;
  // mtvec and boot base use bits at and above this one
  localparam int         VEC_BASE_LSB = 8;
  // all internal interrupts share the nmi vector
  localparam logic [4:0] IRQ_NMI_CODE = 5'd31;

  // words outstanding on the bus plus words queued
  localparam int FIFO_DEPTH  = 2;
  // pc step, every instruction is one word
  localparam int INSTR_BYTES = 4;

endpackage
